// File: files.f
+incdir+common
common/cache_pkg.sv
common/mem_bus_if.sv
dcache/dcache.sv
icache/icache.sv
hdl/mem_arbiter.sv
hdl/cache_top.sv
sim/tb_memory.sv
sim/cache_tb.sv

// File: sim/cache_tb.sv
`timescale 1ns/1ps

module cache_tb
    import cache_pkg::*;
();

    localparam logic [1:0] PORT_D = 2'd0;
    localparam logic [1:0] PORT_I = 2'd1;
    localparam logic [1:0] PORT_B = 2'd2;

    typedef struct packed {
        logic [1:0] port;
        logic       wr;
        proc_addr_t addr;
        proc_addr_t iaddr;
        word_t      wdata;
        word_t      exp;
        word_t      iexp;
        logic       hit;
    } entry_t;

    logic       clk;
    logic       proc_reset;
    logic       data_read;
    logic       data_write;
    proc_addr_t data_addr;
    word_t      data_wdata;
    word_t      data_rdata;
    logic       data_stall;
    logic       inst_read;
    proc_addr_t inst_addr;
    word_t      inst_rdata;
    logic       inst_stall;
    logic       mem_read;
    logic       mem_write;
    mem_addr_t  mem_addr;
    line_t      mem_wdata;
    line_t      mem_rdata;
    logic       mem_ready;

    entry_t stim [$];
    word_t  ref_words [256];
    logic   stim_ready;

    cache_top dut (
        .clk        (clk),
        .proc_reset (proc_reset),
        .data_read  (data_read),
        .data_write (data_write),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_rdata (data_rdata),
        .data_stall (data_stall),
        .inst_read  (inst_read),
        .inst_addr  (inst_addr),
        .inst_rdata (inst_rdata),
        .inst_stall (inst_stall),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready)
    );

    tb_memory u_memory (
        .clk        (clk),
        .proc_reset (proc_reset),
        .read       (mem_read),
        .write      (mem_write),
        .addr       (mem_addr),
        .wdata      (mem_wdata),
        .rdata      (mem_rdata),
        .ready      (mem_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_failed();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            stop_failed();
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
            stop_failed();
        end
    endtask

    // reference model runs while the table is built
    task automatic add_entry(input logic [1:0] port, input logic wr, input proc_addr_t addr,
                             input proc_addr_t iaddr, input word_t wdata, input logic hit);
        entry_t e;
        e.port  = port;
        e.wr    = wr;
        e.addr  = addr;
        e.iaddr = iaddr;
        e.wdata = wdata;
        e.hit   = hit;
        if (wr) begin
            ref_words[addr[7:0]] = wdata;
        end
        e.exp  = ref_words[addr[7:0]];
        e.iexp = ref_words[iaddr[7:0]];
        stim.push_back(e);
    endtask

    task automatic build_stimulus();
        for (int a = 0; a < 256; a++) begin
            ref_words[a] = {2'b01, proc_addr_t'(a)} ^ 32'hC3A5_0F96;
        end
        // set 1 cold read, hits, write hit, write miss
        add_entry(PORT_D, 1'b0, 'h05, 'h0, 'h0, 1'b0);
        add_entry(PORT_D, 1'b0, 'h05, 'h0, 'h0, 1'b1);
        add_entry(PORT_D, 1'b1, 'h06, 'h0, 32'hDEAD_0006, 1'b1);
        add_entry(PORT_D, 1'b0, 'h06, 'h0, 'h0, 1'b1);
        add_entry(PORT_D, 1'b1, 'h15, 'h0, 32'hBEEF_0015, 1'b0);
        add_entry(PORT_D, 1'b0, 'h15, 'h0, 'h0, 1'b1);
        // third tag on set 1 evicts dirty lines through memory
        add_entry(PORT_D, 1'b0, 'h25, 'h0, 'h0, 1'b0);
        add_entry(PORT_D, 1'b0, 'h06, 'h0, 'h0, 1'b0);
        add_entry(PORT_D, 1'b0, 'h15, 'h0, 'h0, 1'b0);
        // lru on set 2
        add_entry(PORT_D, 1'b0, 'h08, 'h0, 'h0, 1'b0);
        add_entry(PORT_D, 1'b0, 'h18, 'h0, 'h0, 1'b0);
        add_entry(PORT_D, 1'b0, 'h08, 'h0, 'h0, 1'b1);
        add_entry(PORT_D, 1'b0, 'h28, 'h0, 'h0, 1'b0);
        add_entry(PORT_D, 1'b0, 'h08, 'h0, 'h0, 1'b1);
        add_entry(PORT_D, 1'b0, 'h18, 'h0, 'h0, 1'b0);
        // instruction region above 0x80 is never written
        add_entry(PORT_I, 1'b0, 'h81, 'h0, 'h0, 1'b0);
        add_entry(PORT_I, 1'b0, 'h81, 'h0, 'h0, 1'b1);
        add_entry(PORT_I, 1'b0, 'h83, 'h0, 'h0, 1'b1);
        // both caches miss together
        add_entry(PORT_B, 1'b0, 'h40, 'h90, 'h0, 1'b0);
        add_entry(PORT_D, 1'b1, 'h41, 'h0, 32'h1234_0041, 1'b1);
        add_entry(PORT_D, 1'b0, 'h41, 'h0, 'h0, 1'b1);
    endtask

    // called 1 ns after a rising edge, returns 1 ns after the completing edge
    task automatic apply_entry(input entry_t e);
        logic d_act;
        logic i_act;
        logic d_fin;
        logic i_fin;
        int   cyc;
        int   d_cyc;
        int   i_cyc;
        d_act      = (e.port != PORT_I);
        i_act      = (e.port != PORT_D);
        cyc        = 0;
        d_cyc      = 0;
        i_cyc      = 0;
        data_read  = d_act && !e.wr;
        data_write = d_act && e.wr;
        data_addr  = e.addr;
        data_wdata = e.wdata;
        inst_read  = i_act;
        inst_addr  = (e.port == PORT_B) ? e.iaddr : e.addr;
        while (d_act || i_act) begin
            @(negedge clk);
            d_fin = d_act && !data_stall;
            i_fin = i_act && !inst_stall;
            // a hit must not stall at all
            if (cyc == 0 && d_act)
                check_flag("data_stall", data_stall, !e.hit);
            if (cyc == 0 && i_act)
                check_flag("inst_stall", inst_stall, !e.hit);
            if (d_fin && !e.wr)
                check_word("data_rdata", data_rdata, e.exp);
            if (i_fin)
                check_word("inst_rdata", inst_rdata, (e.port == PORT_B) ? e.iexp : e.exp);
            @(posedge clk);
            #1;
            if (d_fin) begin
                data_read  = 1'b0;
                data_write = 1'b0;
                d_act      = 1'b0;
                d_cyc      = cyc;
            end
            if (i_fin) begin
                inst_read = 1'b0;
                i_act     = 1'b0;
                i_cyc     = cyc;
            end
            cyc++;
        end
        if (e.port == PORT_B && d_cyc > i_cyc) begin
            $display("data access at %0h finished after the instruction access", e.addr);
            stop_failed();
        end
    endtask

    initial begin
        stim_ready = 1'b0;
        wait (stim_ready);
        repeat (stim.size() * 40 + 200) @(posedge clk);
        $display("watchdog expired before all %0d table entries completed", stim.size());
        stop_failed();
    end

    initial begin
        proc_reset = 1'b0;
        data_read  = 1'b0;
        data_write = 1'b0;
        data_addr  = '0;
        data_wdata = '0;
        inst_read  = 1'b0;
        inst_addr  = '0;
        build_stimulus();
        stim_ready = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        proc_reset = 1'b1;
        @(posedge clk);
        #1;
        foreach (stim[i]) begin
            apply_entry(stim[i]);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: sim/tb_memory.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module tb_memory
    import cache_pkg::*;
#(
    parameter int LATENCY = 3
) (
    input  logic      clk,
    input  logic      proc_reset,
    input  logic      read,
    input  logic      write,
    input  mem_addr_t addr,
    input  line_t     wdata,
    output line_t     rdata,
    output logic      ready
);

    localparam int LINES = 64;

    line_t lines [LINES];
    int    count;

    // initial word depends on the full word address
    function automatic word_t init_word(proc_addr_t wa);
        return {2'b01, wa} ^ 32'hC3A5_0F96;
    endfunction

    initial begin
        for (int la = 0; la < LINES; la++) begin
            for (int w = 0; w < `CACHE_LINE_WORDS; w++) begin
                lines[la][w*`CACHE_WORD_W +: `CACHE_WORD_W] =
                    init_word(proc_addr_t'((la << 2) | w));
            end
        end
    end

    assign rdata = lines[addr[5:0]];

    // ready pulse once the strobe has been held for LATENCY cycles
    always_ff @(posedge clk or negedge proc_reset) begin
        if (!proc_reset) begin
            count <= 0;
            ready <= 1'b0;
        end else if (ready) begin
            count <= 0;
            ready <= 1'b0;
        end else if (read || write) begin
            if (count == LATENCY - 1) begin
                ready <= 1'b1;
            end else begin
                count <= count + 1;
            end
        end
    end

    always @(posedge clk) begin
        if (ready && write) begin
            lines[addr[5:0]] <= wdata;
        end
    end

endmodule

// File: hdl/cache_top.sv
`timescale 1ns/1ps

module cache_top
    import cache_pkg::*;
(
    input  logic       clk,
    input  logic       proc_reset,
    // data side
    input  logic       data_read,
    input  logic       data_write,
    input  proc_addr_t data_addr,
    input  word_t      data_wdata,
    output word_t      data_rdata,
    output logic       data_stall,
    // instruction side
    input  logic       inst_read,
    input  proc_addr_t inst_addr,
    output word_t      inst_rdata,
    output logic       inst_stall,
    // shared memory port
    output logic       mem_read,
    output logic       mem_write,
    output mem_addr_t  mem_addr,
    output line_t      mem_wdata,
    input  line_t      mem_rdata,
    input  logic       mem_ready
);

    mem_bus_if dbus ();
    mem_bus_if ibus ();

    dcache u_dcache (
        .clk        (clk),
        .proc_reset (proc_reset),
        .read       (data_read),
        .write      (data_write),
        .addr       (data_addr),
        .wdata      (data_wdata),
        .rdata      (data_rdata),
        .stall      (data_stall),
        .mem        (dbus.cache)
    );

    icache u_icache (
        .clk        (clk),
        .proc_reset (proc_reset),
        .read       (inst_read),
        .addr       (inst_addr),
        .rdata      (inst_rdata),
        .stall      (inst_stall),
        .mem        (ibus.cache)
    );

    mem_arbiter u_mem_arbiter (
        .clk        (clk),
        .proc_reset (proc_reset),
        .dbus       (dbus.arbiter),
        .ibus       (ibus.arbiter),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready)
    );

endmodule

// File: hdl/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        proc_reset,
    mem_bus_if.arbiter  dbus,
    mem_bus_if.arbiter  ibus,
    output logic        mem_read,
    output logic        mem_write,
    output mem_addr_t   mem_addr,
    output line_t       mem_wdata,
    input  line_t       mem_rdata,
    input  logic        mem_ready
);

    logic busy;
    // set when the instruction cache holds the grant
    logic owner;
    logic d_req, i_req;
    logic sel_inst;

    assign d_req = dbus.read || dbus.write;
    assign i_req = ibus.read || ibus.write;

    // data bus wins a tie, grant sticks until ready
    assign sel_inst = busy ? owner : (!d_req && i_req);

    assign mem_read  = sel_inst ? ibus.read  : dbus.read;
    assign mem_write = sel_inst ? ibus.write : dbus.write;
    assign mem_addr  = sel_inst ? ibus.addr  : dbus.addr;
    assign mem_wdata = sel_inst ? ibus.wdata : dbus.wdata;

    assign dbus.ready = mem_ready && busy && !owner;
    assign ibus.ready = mem_ready && busy && owner;
    assign dbus.rdata = owner ? '0 : mem_rdata;
    assign ibus.rdata = owner ? mem_rdata : '0;

    always_ff @(posedge clk or negedge proc_reset) begin
        if (!proc_reset) begin
            busy  <= 1'b0;
            owner <= 1'b0;
        end else if (!busy && (d_req || i_req)) begin
            busy  <= 1'b1;
            owner <= sel_inst;
        end else if (busy && mem_ready) begin
            busy <= 1'b0;
        end
    end

    a_ready_when_busy: assert property (@(posedge clk) disable iff (!proc_reset)
        mem_ready |-> busy);

endmodule

// File: icache/icache.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module icache
    import cache_pkg::*;
(
    input  logic       clk,
    input  logic       proc_reset,
    input  logic       read,
    input  proc_addr_t addr,
    output word_t      rdata,
    output logic       stall,
    mem_bus_if.cache   mem
);

    line_t data_mem [`CACHE_SETS][`CACHE_WAYS];
    tag_t  tag_mem  [`CACHE_SETS][`CACHE_WAYS];

    logic [`CACHE_SETS-1:0][`CACHE_WAYS-1:0] valid;
    logic [`CACHE_SETS-1:0]                  lru;

    cache_state_e state, next_state;

    tag_t    req_tag;
    index_t  req_index;
    offset_t req_offset;
    logic    hit0, hit1, hit;
    way_t    hit_way, victim;
    logic    fill;

    assign req_tag    = addr_tag(addr);
    assign req_index  = addr_index(addr);
    assign req_offset = addr_offset(addr);

    assign hit0    = valid[req_index][0] && (tag_mem[req_index][0] == req_tag);
    assign hit1    = valid[req_index][1] && (tag_mem[req_index][1] == req_tag);
    assign hit     = hit0 || hit1;
    assign hit_way = !hit0;

    assign victim = !valid[req_index][0] ? 1'b0 :
                    !valid[req_index][1] ? 1'b1 : lru[req_index];

    assign fill  = (state == S_ALLOCATE) && mem.ready;
    assign rdata = line_word(data_mem[req_index][hit_way], req_offset);

    // read-only, lines are never written back
    assign mem.write = 1'b0;
    assign mem.wdata = '0;
    assign mem.addr  = {req_tag, req_index};
    assign mem.read  = (state == S_ALLOCATE) || ((state == S_IDLE) && read && !hit);
    assign stall     = mem.read;

    always_comb begin
        next_state = state;
        case (state)
            S_IDLE:     if (read && !hit) next_state = S_ALLOCATE;
            S_ALLOCATE: if (mem.ready) next_state = S_OUTPUT;
            default:    next_state = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge proc_reset) begin
        if (!proc_reset) begin
            state <= S_IDLE;
            valid <= '0;
            lru   <= '0;
        end else begin
            state <= next_state;
            if ((state == S_IDLE) && read && hit) begin
                lru[req_index] <= ~hit_way;
            end
            if (fill) begin
                valid[req_index][victim] <= 1'b1;
                lru[req_index]           <= ~victim;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            data_mem[req_index][victim] <= mem.rdata;
            tag_mem[req_index][victim]  <= req_tag;
        end
    end

    a_no_write: assert property (@(posedge clk) disable iff (!proc_reset)
        !mem.write);

endmodule

// File: dcache/dcache.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module dcache
    import cache_pkg::*;
(
    input  logic       clk,
    input  logic       proc_reset,
    input  logic       read,
    input  logic       write,
    input  proc_addr_t addr,
    input  word_t      wdata,
    output word_t      rdata,
    output logic       stall,
    mem_bus_if.cache   mem
);

    // line storage, no reset
    line_t data_mem [`CACHE_SETS][`CACHE_WAYS];
    tag_t  tag_mem  [`CACHE_SETS][`CACHE_WAYS];

    logic [`CACHE_SETS-1:0][`CACHE_WAYS-1:0] valid;
    logic [`CACHE_SETS-1:0][`CACHE_WAYS-1:0] dirty;
    // points at the way to replace next
    logic [`CACHE_SETS-1:0]                  lru;

    cache_state_e state, next_state;

    tag_t    req_tag;
    index_t  req_index;
    offset_t req_offset;
    logic    req;
    logic    hit0, hit1, hit;
    way_t    hit_way, victim;
    logic    victim_dirty;
    logic    hit_access, fill;
    line_t   hit_line, fill_line;

    assign req_tag    = addr_tag(addr);
    assign req_index  = addr_index(addr);
    assign req_offset = addr_offset(addr);
    assign req        = read || write;

    assign hit0    = valid[req_index][0] && (tag_mem[req_index][0] == req_tag);
    assign hit1    = valid[req_index][1] && (tag_mem[req_index][1] == req_tag);
    assign hit     = hit0 || hit1;
    assign hit_way = !hit0;

    // invalid way first, else the lru way
    assign victim = !valid[req_index][0] ? 1'b0 :
                    !valid[req_index][1] ? 1'b1 : lru[req_index];
    assign victim_dirty = valid[req_index][victim] && dirty[req_index][victim];

    assign hit_access = (state == S_IDLE) && req && hit;
    assign fill       = (state == S_ALLOCATE) && mem.ready;

    // also serves the output cycle, the refilled line hits by then
    assign rdata = line_word(data_mem[req_index][hit_way], req_offset);

    assign mem.addr  = mem.write ? {tag_mem[req_index][victim], req_index}
                                 : {req_tag, req_index};
    assign mem.wdata = data_mem[req_index][victim];

    always_comb begin
        hit_line  = data_mem[req_index][hit_way];
        hit_line[req_offset*`CACHE_WORD_W +: `CACHE_WORD_W] = wdata;
        fill_line = mem.rdata;
        fill_line[req_offset*`CACHE_WORD_W +: `CACHE_WORD_W] = wdata;
    end

    always_comb begin
        next_state = state;
        stall      = 1'b0;
        mem.read   = 1'b0;
        mem.write  = 1'b0;
        case (state)
            S_IDLE: begin
                if (req && !hit) begin
                    stall = 1'b1;
                    if (victim_dirty) begin
                        mem.write  = 1'b1;
                        next_state = S_WRITE_BACK;
                    end else begin
                        mem.read   = 1'b1;
                        next_state = S_ALLOCATE;
                    end
                end
            end
            S_WRITE_BACK: begin
                stall     = 1'b1;
                mem.write = 1'b1;
                if (mem.ready) begin
                    next_state = S_ALLOCATE;
                end
            end
            S_ALLOCATE: begin
                mem.read = 1'b1;
                // a write miss finishes in the ready cycle
                stall    = !(mem.ready && write);
                if (mem.ready) begin
                    next_state = read ? S_OUTPUT : S_IDLE;
                end
            end
            S_OUTPUT: next_state = S_IDLE;
            default:  next_state = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge proc_reset) begin
        if (!proc_reset) begin
            state <= S_IDLE;
            valid <= '0;
            dirty <= '0;
            lru   <= '0;
        end else begin
            state <= next_state;
            if (hit_access) begin
                lru[req_index] <= ~hit_way;
                if (write) begin
                    dirty[req_index][hit_way] <= 1'b1;
                end
            end
            if (fill) begin
                valid[req_index][victim] <= 1'b1;
                dirty[req_index][victim] <= write;
                lru[req_index]           <= ~victim;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            data_mem[req_index][victim] <= write ? fill_line : mem.rdata;
            tag_mem[req_index][victim]  <= req_tag;
        end else if (hit_access && write) begin
            data_mem[req_index][hit_way] <= hit_line;
        end
    end

    a_no_read_write: assert property (@(posedge clk) disable iff (!proc_reset)
        !(mem.read && mem.write));

    // the ready cycle of a write miss already completes the processor access
    a_stall_on_mem: assert property (@(posedge clk) disable iff (!proc_reset)
        (mem.read || mem.write) && !mem.ready |-> stall);

endmodule

// File: common/mem_bus_if.sv
`timescale 1ns/1ps

// one cache's path to the shared memory port
interface mem_bus_if
    import cache_pkg::*;
();

    logic      read;
    logic      write;
    mem_addr_t addr;
    line_t     wdata;
    line_t     rdata;
    // single-cycle completion pulse
    logic      ready;

    modport cache (
        output read, write, addr, wdata,
        input  rdata, ready
    );

    modport arbiter (
        input  read, write, addr, wdata,
        output rdata, ready
    );

endinterface

// File: common/cache_pkg.sv
`include "cache_config.svh"

package cache_pkg;

    typedef logic [`CACHE_WORD_W-1:0]      word_t;
    typedef logic [`CACHE_LINE_W-1:0]      line_t;
    typedef logic [`CACHE_TAG_W-1:0]       tag_t;
    typedef logic [`CACHE_INDEX_W-1:0]     index_t;
    typedef logic [`CACHE_OFFSET_W-1:0]    offset_t;
    typedef logic [`CACHE_PROC_ADDR_W-1:0] proc_addr_t;
    typedef logic [`CACHE_MEM_ADDR_W-1:0]  mem_addr_t;
    typedef logic                          way_t;

    // controller states shared by both caches
    typedef enum logic [1:0] {
        S_IDLE       = 2'd0,
        S_WRITE_BACK = 2'd1,
        S_ALLOCATE   = 2'd2,
        S_OUTPUT     = 2'd3
    } cache_state_e;

    function automatic tag_t addr_tag(proc_addr_t a);
        return a[`CACHE_PROC_ADDR_W-1 -: `CACHE_TAG_W];
    endfunction

    function automatic index_t addr_index(proc_addr_t a);
        return a[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
    endfunction

    function automatic offset_t addr_offset(proc_addr_t a);
        return a[`CACHE_OFFSET_W-1:0];
    endfunction

    // word 0 sits in the low bits of the line
    function automatic word_t line_word(line_t line, offset_t off);
        return line[off*`CACHE_WORD_W +: `CACHE_WORD_W];
    endfunction

endpackage

// File: common/cache_config.svh
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// processor word and line geometry
`define CACHE_WORD_W       32
`define CACHE_LINE_WORDS   4
`define CACHE_LINE_W       (`CACHE_LINE_WORDS * `CACHE_WORD_W)

// two-way, four-set organisation
`define CACHE_SETS         4
`define CACHE_WAYS         2

// address split, word-addressed on the processor side
`define CACHE_OFFSET_W     2
`define CACHE_INDEX_W      2
`define CACHE_TAG_W        26
`define CACHE_PROC_ADDR_W  30

// memory side is line-addressed
`define CACHE_MEM_ADDR_W   (`CACHE_TAG_W + `CACHE_INDEX_W)

`endif
